//--- verilog/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Cache and memory data word
`define DCACHE_DATA_W 32
// Pattern ROM word, low half is the write data
`define DCACHE_ROM_W 64
// Word address as stepped by the exerciser
`define DCACHE_ADDR_W 16
// Memory side address
`define DCACHE_MEM_ADDR_W 28

////////////////////////////////////////////////////////////////////////////
// Sizes and default timing
////////////////////////////////////////////////////////////////////////////

// Sweep is larger than the cache, so lines get evicted
`define DCACHE_SWEEP_LEN 64
// 16 lines
`define DCACHE_INDEX_W 4
// Idle cycles between commands
`define DCACHE_GAP_DEFAULT 1
// Backing memory response delay
`define DCACHE_MEM_LAT_DEFAULT 3

`endif

//--- verilog/dcache_pkg.sv
`include "dcache_macros.svh"

package dcache_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Plain vector types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [`DCACHE_DATA_W-1:0] data_t;
	typedef logic [`DCACHE_ROM_W-1:0] rom_word_t;
	typedef logic [`DCACHE_ADDR_W-1:0] waddr_t;
	typedef logic [`DCACHE_MEM_ADDR_W-1:0] mem_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////

	// Exerciser to cache command, rw ignored when flush is set
	typedef struct packed {
		mem_addr_t addr;
		data_t wdata;
		logic rw;
		logic flush;
	} cache_req_t;

	// Cache to memory command, rw high for a write
	typedef struct packed {
		mem_addr_t addr;
		data_t wdata;
		logic rw;
	} mem_req_t;

	// Memory write as seen from outside
	typedef struct packed {
		mem_addr_t addr;
		data_t data;
	} mem_wr_obs_t;

	// Exerciser FSM
	typedef enum logic [2:0] {idle_gap, write_req, read_req, flush_req, verify_req} exer_state_t;

	// Cache FSM
	typedef enum logic [1:0] {ready, evict, fill, flush_walk} cache_state_t;

endpackage

//--- verilog/cache_exerciser.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module cache_exerciser #(
	parameter int GAP_CYCLES = `DCACHE_GAP_DEFAULT
)
(
	input logic clk,
	input logic rst,
	input dcache_pkg::rom_word_t rom_data,
	input dcache_pkg::data_t cache_rdata,
	input logic cache_ready,
	output dcache_pkg::waddr_t rom_addr,
	output dcache_pkg::cache_req_t cache_req,
	output logic cache_valid,
	output logic error,
	output logic flush_active,
	output logic sweep_done
);
	import dcache_pkg::*;

	localparam int GAP_W = (GAP_CYCLES > 1) ? $clog2(GAP_CYCLES) : 1;
	localparam waddr_t LAST_ADDR = waddr_t'(`DCACHE_SWEEP_LEN - 1);

	exer_state_t state;
	// Command to issue once the gap runs out
	exer_state_t next_cmd;
	logic [GAP_W-1:0] gap_cnt;

	logic gap_done;
	logic is_read;
	logic last_addr;
	logic rd_mismatch;

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	// Gap ends after GAP_CYCLES idle cycles
	// Restart waits out the sweep_done cycle so a reloaded pattern table is settled
	assign gap_done = (state == idle_gap) && !sweep_done &&
		(gap_cnt == GAP_W'(GAP_CYCLES - 1));

	assign is_read = (state == read_req) || (state == verify_req);
	assign last_addr = (rom_addr == LAST_ADDR);

	// ROM address still points at the read word in the ready cycle
	assign rd_mismatch = (cache_rdata != rom_data[`DCACHE_DATA_W-1:0]);

	////////////////////////////////////////////////////////////////////////////
	// Sweep FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= idle_gap;
			// First command after reset is a write to address 0
			next_cmd <= write_req;
			gap_cnt <= '0;
			rom_addr <= '0;
			cache_valid <= 1'b0;
			error <= 1'b0;
			flush_active <= 1'b0;
			sweep_done <= 1'b0;
		end
		else
		begin
			sweep_done <= 1'b0;
			case (state)
				idle_gap:
				begin
					if (gap_done)
					begin
						// Launch while the payload block loads the request fields
						state <= next_cmd;
						cache_valid <= 1'b1;
						gap_cnt <= '0;
						flush_active <= (next_cmd == flush_req);
					end
					else if (!sweep_done)
					begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default:
				begin
					// Any command waits for its single ready pulse
					if (cache_ready)
					begin
						state <= idle_gap;
						cache_valid <= 1'b0;
						flush_active <= 1'b0;
						// Reads compare and every other completion clears
						error <= is_read && rd_mismatch;
						case (state)
							write_req:
							begin
								next_cmd <= read_req;
							end
							read_req:
							begin
								if (last_addr)
								begin
									// End of write sweep
									rom_addr <= '0;
									next_cmd <= flush_req;
								end
								else
								begin
									rom_addr <= rom_addr + 1'b1;
									next_cmd <= write_req;
								end
							end
							flush_req:
							begin
								next_cmd <= verify_req;
							end
							default:
							begin
								// Read-only verify sweep
								if (last_addr)
								begin
									rom_addr <= '0;
									next_cmd <= write_req;
									sweep_done <= 1'b1;
								end
								else
								begin
									rom_addr <= rom_addr + 1'b1;
									next_cmd <= verify_req;
								end
							end
						endcase
					end
				end
			endcase
		end
	end

	// Request word held for the whole command
	always_ff @(posedge clk)
	begin
		if (gap_done)
		begin
			cache_req.addr <= mem_addr_t'(rom_addr);
			cache_req.wdata <= rom_data[`DCACHE_DATA_W-1:0];
			cache_req.rw <= (next_cmd == write_req);
			cache_req.flush <= (next_cmd == flush_req);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Command stays up and unchanged until the cache answers
	assert property (@(posedge clk) disable iff (rst)
		cache_valid && !cache_ready |=> cache_valid && $stable(cache_req));

endmodule

//--- verilog/dcache.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache #(
	parameter int INDEX_W = `DCACHE_INDEX_W
)
(
	input logic clk,
	input logic rst,
	input dcache_pkg::cache_req_t cache_req,
	input logic cache_valid,
	input dcache_pkg::data_t mem_rdata,
	input logic mem_ready,
	output dcache_pkg::data_t cache_rdata,
	output logic cache_ready,
	output dcache_pkg::mem_req_t mem_req,
	output logic mem_valid
);
	import dcache_pkg::*;

	localparam int LINES = 1 << INDEX_W;
	localparam int TAG_W = `DCACHE_MEM_ADDR_W - INDEX_W;

	cache_state_t state;

	// One-word lines
	data_t line_data [LINES];
	logic [TAG_W-1:0] line_tag [LINES];
	logic [LINES-1:0] line_valid;
	logic [LINES-1:0] line_dirty;
	// Flush position
	logic [INDEX_W-1:0] walk_idx;

	logic [INDEX_W-1:0] req_idx;
	logic [TAG_W-1:0] req_tag;
	logic accept;
	logic hit;
	logic victim_dirty;
	logic wb_needed;
	logic mem_done;
	logic issue_evict;
	logic issue_fill;
	logic issue_wb;
	logic walk_step;
	logic walk_last;

	////////////////////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////////////////////

	assign req_idx = cache_req.addr[INDEX_W-1:0];
	assign req_tag = cache_req.addr[`DCACHE_MEM_ADDR_W-1:INDEX_W];
	assign hit = line_valid[req_idx] && (line_tag[req_idx] == req_tag);
	assign victim_dirty = line_valid[req_idx] && line_dirty[req_idx];

	// New command only, the ready cycle still sees the old valid
	assign accept = (state == ready) && cache_valid && !cache_ready;

	// Memory side, each state raises mem_valid on entry and waits
	assign mem_done = mem_valid && mem_ready;
	assign issue_evict = (state == evict) && !mem_valid;
	assign issue_fill = (state == fill) && !mem_valid;
	assign wb_needed = line_valid[walk_idx] && line_dirty[walk_idx];
	assign issue_wb = (state == flush_walk) && !mem_valid && wb_needed;

	// Clean lines step at once, dirty ones after their write-back
	assign walk_step = (state == flush_walk) && (mem_valid ? mem_ready : !wb_needed);
	assign walk_last = (walk_idx == INDEX_W'(LINES - 1));

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ready;
			line_valid <= '0;
			line_dirty <= '0;
			walk_idx <= '0;
			cache_ready <= 1'b0;
			mem_valid <= 1'b0;
		end
		else
		begin
			cache_ready <= 1'b0;
			case (state)
				ready:
				begin
					if (accept)
					begin
						if (cache_req.flush)
						begin
							state <= flush_walk;
							walk_idx <= '0;
						end
						else if (hit)
						begin
							// Hit answers on the next cycle
							cache_ready <= 1'b1;
							if (cache_req.rw)
								line_dirty[req_idx] <= 1'b1;
						end
						else if (victim_dirty)
							state <= evict;
						else
							state <= fill;
					end
				end
				evict:
				begin
					if (issue_evict)
						mem_valid <= 1'b1;
					else if (mem_done)
					begin
						mem_valid <= 1'b0;
						line_dirty[req_idx] <= 1'b0;
						state <= fill;
					end
				end
				fill:
				begin
					if (issue_fill)
						mem_valid <= 1'b1;
					else if (mem_done)
					begin
						// Write-allocate, a write leaves the line dirty
						mem_valid <= 1'b0;
						line_valid[req_idx] <= 1'b1;
						line_dirty[req_idx] <= cache_req.rw;
						cache_ready <= 1'b1;
						state <= ready;
					end
				end
				default:
				begin
					if (issue_wb)
						mem_valid <= 1'b1;
					else if (mem_done)
					begin
						mem_valid <= 1'b0;
						line_dirty[walk_idx] <= 1'b0;
					end
					if (walk_step)
					begin
						if (walk_last)
						begin
							cache_ready <= 1'b1;
							state <= ready;
						end
						else
							walk_idx <= walk_idx + 1'b1;
					end
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Line storage and payload
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (accept && !cache_req.flush && hit)
		begin
			cache_rdata <= cache_req.rw ? cache_req.wdata : line_data[req_idx];
			if (cache_req.rw)
				line_data[req_idx] <= cache_req.wdata;
		end
		if ((state == fill) && mem_done)
		begin
			// Merge the write word over the filled word
			line_tag[req_idx] <= req_tag;
			line_data[req_idx] <= cache_req.rw ? cache_req.wdata : mem_rdata;
			cache_rdata <= cache_req.rw ? cache_req.wdata : mem_rdata;
		end
		// Victim address rebuilt from its stored tag
		if (issue_evict)
			mem_req <= '{addr: {line_tag[req_idx], req_idx}, wdata: line_data[req_idx], rw: 1'b1};
		if (issue_fill)
			mem_req <= '{addr: cache_req.addr, wdata: cache_req.wdata, rw: 1'b0};
		if (issue_wb)
			mem_req <= '{addr: {line_tag[walk_idx], walk_idx}, wdata: line_data[walk_idx], rw: 1'b1};
	end

	// Memory is only busy while a miss or a flush is in progress
	assert property (@(posedge clk) disable iff (rst) (state == ready) |-> !mem_valid);

	// Answers only to a command still held by the exerciser
	assert property (@(posedge clk) disable iff (rst) cache_ready |-> cache_valid);

endmodule

//--- verilog/backing_mem.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module backing_mem #(
	parameter int LATENCY = `DCACHE_MEM_LAT_DEFAULT,
	parameter int DEPTH_W = 8
)
(
	input logic clk,
	input logic rst,
	input dcache_pkg::mem_req_t mem_req,
	input logic mem_valid,
	output dcache_pkg::data_t mem_rdata,
	output logic mem_ready,
	output dcache_pkg::mem_wr_obs_t mem_wr_obs,
	output logic mem_wr_strobe
);
	import dcache_pkg::*;

	localparam int CNT_W = $clog2(LATENCY + 1);

	data_t mem_array [1 << DEPTH_W];
	logic busy;
	logic [CNT_W-1:0] cnt;
	logic start;
	logic done;
	logic [DEPTH_W-1:0] word_idx;

	// Low address bits select the word
	assign word_idx = mem_req.addr[DEPTH_W-1:0];

	// Requester still holds valid during the ready cycle, so skip that one
	assign start = !busy && mem_valid && !mem_ready;
	assign done = (busy && (cnt == CNT_W'(1))) || (start && (LATENCY <= 1));

	// Countdown, ready lands LATENCY cycles after valid is first seen
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			cnt <= '0;
			mem_ready <= 1'b0;
			mem_wr_strobe <= 1'b0;
		end
		else
		begin
			mem_ready <= done;
			mem_wr_strobe <= done && mem_req.rw;
			if (start && (LATENCY > 1))
			begin
				busy <= 1'b1;
				cnt <= CNT_W'(LATENCY - 1);
			end
			else if (busy)
			begin
				if (done)
					busy <= 1'b0;
				else
					cnt <= cnt - 1'b1;
			end
		end
	end

	// Access, reported alongside ready
	always_ff @(posedge clk)
	begin
		if (done)
		begin
			if (mem_req.rw)
			begin
				mem_array[word_idx] <= mem_req.wdata;
				mem_wr_obs <= '{addr: mem_req.addr, data: mem_req.wdata};
			end
			else
				mem_rdata <= mem_array[word_idx];
		end
	end

	// Requester holds its command for the whole countdown
	assert property (@(posedge clk) disable iff (rst) busy |-> mem_valid && $stable(mem_req));

endmodule

//--- verilog/dcache_subsys.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_subsys #(
	parameter int GAP_CYCLES = `DCACHE_GAP_DEFAULT,
	parameter int MEM_LATENCY = `DCACHE_MEM_LAT_DEFAULT
)
(
	input logic clk,
	input logic rst,
	input dcache_pkg::rom_word_t rom_data,
	output dcache_pkg::waddr_t rom_addr,
	output logic error,
	output logic flush_active,
	output logic sweep_done,
	output dcache_pkg::mem_wr_obs_t mem_wr_obs,
	output logic mem_wr_strobe
);
	import dcache_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Internal buses
	////////////////////////////////////////////////////////////////////////////

	// Exerciser to cache
	cache_req_t cache_req;
	logic cache_valid;
	data_t cache_rdata;
	logic cache_ready;

	// Cache to memory
	mem_req_t mem_req;
	logic mem_valid;
	data_t mem_rdata;
	logic mem_ready;

	// Traffic source and checker of readback data
	cache_exerciser #(
		.GAP_CYCLES(GAP_CYCLES)
	) u_exerciser (
		.clk(clk),
		.rst(rst),
		.rom_data(rom_data),
		.cache_rdata(cache_rdata),
		.cache_ready(cache_ready),
		.rom_addr(rom_addr),
		.cache_req(cache_req),
		.cache_valid(cache_valid),
		.error(error),
		.flush_active(flush_active),
		.sweep_done(sweep_done)
	);

	dcache u_dcache (
		.clk(clk),
		.rst(rst),
		.cache_req(cache_req),
		.cache_valid(cache_valid),
		.mem_rdata(mem_rdata),
		.mem_ready(mem_ready),
		.cache_rdata(cache_rdata),
		.cache_ready(cache_ready),
		.mem_req(mem_req),
		.mem_valid(mem_valid)
	);

	// DRAM stand-in
	backing_mem #(
		.LATENCY(MEM_LATENCY)
	) u_backing_mem (
		.clk(clk),
		.rst(rst),
		.mem_req(mem_req),
		.mem_valid(mem_valid),
		.mem_rdata(mem_rdata),
		.mem_ready(mem_ready),
		.mem_wr_obs(mem_wr_obs),
		.mem_wr_strobe(mem_wr_strobe)
	);

endmodule

//--- test/dcache_checker.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_checker #(
	parameter int SWEEPS = 3
)
(
	input logic clk,
	input logic rst,
	input dcache_pkg::rom_word_t [`DCACHE_SWEEP_LEN-1:0] pattern,
	input dcache_pkg::waddr_t rom_addr,
	input logic error,
	input logic flush_active,
	input logic sweep_done,
	input dcache_pkg::mem_wr_obs_t mem_wr_obs,
	input logic mem_wr_strobe,
	output int fail_count,
	output logic report_done
);
	import dcache_pkg::*;

	localparam int LEN = `DCACHE_SWEEP_LEN;
	localparam int AW = $clog2(LEN);
	localparam mem_addr_t SWEEP_END = mem_addr_t'(LEN);

	// Test numbers
	localparam logic [2:0] T_RESET = 3'd0;
	localparam logic [2:0] T_READBACK = 3'd1;
	localparam logic [2:0] T_MEM_WR = 3'd2;
	localparam logic [2:0] T_FLUSH = 3'd3;
	localparam logic [2:0] T_SWEEP = 3'd4;

	int checks [5];
	int fails [5];
	int total_checks = 0;
	int total_fails = 0;
	logic finished = 1'b0;

	// Reference memory holding the last word written per sweep address
	data_t model_mem [LEN];
	logic [LEN-1:0] written = '0;

	logic reset_reported = 1'b0;
	logic flush_prev = 1'b0;
	logic sweep_prev = 1'b0;
	int flushes_in_sweep = 0;
	int sweeps = 0;

	assign fail_count = total_fails;
	assign report_done = finished;

	////////////////////////////////////////////////////////////////////////////
	// Bookkeeping
	////////////////////////////////////////////////////////////////////////////

	task automatic tally(input logic [2:0] test, input logic ok);
		checks[test] = checks[test] + 1;
		total_checks = total_checks + 1;
		if (ok !== 1'b1)
		begin
			fails[test] = fails[test] + 1;
			total_fails = total_fails + 1;
		end
	endtask

	task automatic compare_value(input logic [2:0] test, input string name,
		input logic [31:0] expected, input logic [31:0] actual);
		tally(test, expected === actual);
		if (expected !== actual)
			$display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
	endtask

	task automatic fail_plain(input logic [2:0] test, input string text);
		tally(test, 1'b0);
		$display("%s, at %0t", text, $time);
	endtask

	task automatic print_test_line(input logic [2:0] test, input string name);
		$display("Test %s: %0d checks, %0d failures, %s", name, checks[test], fails[test],
			(fails[test] == 0) ? "pass" : "fail");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_reset_outputs();
		compare_value(T_RESET, "error", 32'd0, 32'(error));
		compare_value(T_RESET, "flush_active", 32'd0, 32'(flush_active));
		compare_value(T_RESET, "sweep_done", 32'd0, 32'(sweep_done));
		compare_value(T_RESET, "mem_wr_strobe", 32'd0, 32'(mem_wr_strobe));
		compare_value(T_RESET, "rom_addr", 32'd0, 32'(rom_addr));
	endtask

	// Every sweep address must have reached memory by the end of a flush
	task automatic check_flush();
		logic [AW-1:0] idx;
		for (int i = 0; i < LEN; i++)
		begin
			idx = AW'(i);
			if (!written[idx])
				fail_plain(T_FLUSH, $sformatf("Flush ended with address %0d never in memory", i));
			else
				compare_value(T_FLUSH, $sformatf("memory word %0d", i),
					pattern[idx][`DCACHE_DATA_W-1:0], model_mem[idx]);
		end
	endtask

	task automatic final_report();
		print_test_line(T_READBACK, "readback");
		print_test_line(T_MEM_WR, "memory_writes");
		print_test_line(T_FLUSH, "flush_complete");
		print_test_line(T_SWEEP, "sweep_progress");
		$display("Totals: %0d checks, %0d failures", total_checks, total_fails);
		finished = 1'b1;
	endtask

	task automatic watch_cycle();
		logic [AW-1:0] idx;
		// First cycle out of reset still shows reset values
		if (!reset_reported)
		begin
			check_reset_outputs();
			print_test_line(T_RESET, "reset_state");
			reset_reported = 1'b1;
		end
		// Exerciser flags any readback that differs from the ROM
		compare_value(T_READBACK, "error", 32'd0, 32'(error));
		if (rom_addr >= waddr_t'(LEN))
			fail_plain(T_SWEEP, $sformatf("rom_addr %0d is outside the sweep", rom_addr));
		else
			tally(T_SWEEP, 1'b1);
		if (mem_wr_strobe)
		begin
			if (mem_wr_obs.addr >= SWEEP_END)
				fail_plain(T_MEM_WR, $sformatf("Memory write to address %0d, outside the sweep",
					mem_wr_obs.addr));
			else
			begin
				idx = mem_wr_obs.addr[AW-1:0];
				compare_value(T_MEM_WR, "mem_wr_obs.data",
					pattern[idx][`DCACHE_DATA_W-1:0], mem_wr_obs.data);
				model_mem[idx] = mem_wr_obs.data;
				written[idx] = 1'b1;
			end
		end
		// Falling edge of flush_active ends the flush
		if (flush_prev && !flush_active)
		begin
			check_flush();
			flushes_in_sweep = flushes_in_sweep + 1;
		end
		flush_prev = flush_active;
		if (sweep_done)
		begin
			if (sweep_prev)
				fail_plain(T_SWEEP, "sweep_done stayed high for more than one cycle");
			else
			begin
				// One flush per sweep
				compare_value(T_SWEEP, "flushes per sweep", 32'd1, 32'(flushes_in_sweep));
				flushes_in_sweep = 0;
				sweeps = sweeps + 1;
			end
		end
		sweep_prev = sweep_done;
		if (sweeps == SWEEPS)
			final_report();
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk)
	begin
		if (rst)
			check_reset_outputs();
		else if (!finished)
			watch_cycle();
	end

endmodule

//--- test/tb_dcache_subsys.sv
`timescale 1ns/1ps
`include "dcache_macros.svh"

module tb_dcache_subsys;
	import dcache_pkg::*;

	localparam int SWEEPS = 3;
	localparam int GAP = `DCACHE_GAP_DEFAULT;
	localparam int MEM_LAT = `DCACHE_MEM_LAT_DEFAULT;
	localparam int LEN = `DCACHE_SWEEP_LEN;
	localparam int AW = $clog2(LEN);
	localparam int LINES = 1 << `DCACHE_INDEX_W;

	////////////////////////////////////////////////////////////////////////////
	// Run length bound
	////////////////////////////////////////////////////////////////////////////

	// One memory access with its handshake cycles
	localparam int ROUND_TRIP = MEM_LAT + 3;
	// Worst flush, every line dirty
	localparam int FLUSH_CYCLES = LINES * ROUND_TRIP;
	localparam int PER_ADDR = GAP + 2 * ROUND_TRIP + FLUSH_CYCLES;
	localparam int TIMEOUT_CYCLES = SWEEPS * LEN * PER_ADDR + 1000;

	logic clk;
	logic rst;
	// Pattern ROM contents, owned here
	rom_word_t [LEN-1:0] pattern;
	rom_word_t rom_data;
	waddr_t rom_addr;
	logic error;
	logic flush_active;
	logic sweep_done;
	mem_wr_obs_t mem_wr_obs;
	logic mem_wr_strobe;
	int fail_count;
	logic report_done;
	int seed = 32'h2926;

	// Two draws make one ROM word
	function automatic rom_word_t next_word();
		return {$random(seed), $random(seed)};
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Pattern ROM
	////////////////////////////////////////////////////////////////////////////

	// New table after every sweep, exerciser idles through that edge
	initial
	begin
		for (int i = 0; i < LEN; i++)
			pattern[AW'(i)] = next_word();
		forever
		begin
			@(posedge clk);
			if (!rst && sweep_done)
			begin
				for (int i = 0; i < LEN; i++)
					pattern[AW'(i)] <= next_word();
			end
		end
	end

	// Combinational read
	always_comb
	begin
		if (rom_addr < waddr_t'(LEN))
			rom_data = pattern[rom_addr[AW-1:0]];
		else
			rom_data = '0;
	end

	dcache_subsys #(
		.GAP_CYCLES(GAP),
		.MEM_LATENCY(MEM_LAT)
	) UUT (
		.clk(clk),
		.rst(rst),
		.rom_data(rom_data),
		.rom_addr(rom_addr),
		.error(error),
		.flush_active(flush_active),
		.sweep_done(sweep_done),
		.mem_wr_obs(mem_wr_obs),
		.mem_wr_strobe(mem_wr_strobe)
	);

	dcache_checker #(
		.SWEEPS(SWEEPS)
	) u_checker (
		.clk(clk),
		.rst(rst),
		.pattern(pattern),
		.rom_addr(rom_addr),
		.error(error),
		.flush_active(flush_active),
		.sweep_done(sweep_done),
		.mem_wr_obs(mem_wr_obs),
		.mem_wr_strobe(mem_wr_strobe),
		.fail_count(fail_count),
		.report_done(report_done)
	);

	// End of run once the checker has printed its results
	initial
	begin
		wait (report_done);
		if (fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: %0d sweeps did not finish within %0d cycles", SWEEPS,
			TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- flist.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/cache_exerciser.sv
verilog/dcache.sv
verilog/backing_mem.sv
verilog/dcache_subsys.sv
test/dcache_checker.sv
test/tb_dcache_subsys.sv

//--- Makefile
# Verilator build, run and lint for the data-cache exerciser testbench

TOP := tb_dcache_subsys
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f verilog/*.sv verilog/*.svh test/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f flist.f

# The run passes only if the log holds the pass line
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir $(LOG)
